//--- Bender.yml
package:
  name: vread

sources:
  - include_dirs:
      - .
    files:
      - vReadPkg.sv
      - addressGen.sv
      - addressGen2.sv
      - memoryWriter.sv
      - dualPortRam.sv
      - vRead.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_vRead.sv

//--- addressGen.sv
`timescale 1ns/1ps

module addressGen
   import vReadPkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     run,
   input  memAddr_t iterations,
   input  period_t  period,
   input  period_t  duty,
   input  memAddr_t shift,
   input  memAddr_t incr,
   output logic     valid,
   input  logic     ready,
   output memAddr_t addr,
   output logic     done
);

   genPhase_t phase;
   memAddr_t  iterCnt;
   period_t   perCnt;
   memAddr_t  addrAcc;
   logic      inDuty;
   logic      lastStep;
   logic      lastIter;
   logic      advance;
   memAddr_t  stepIncr;

   assign inDuty   = (perCnt < duty);
   assign lastStep = (perCnt == period - 1'b1);
   assign lastIter = (iterCnt == iterations - 1'b1);

   // steps outside the duty window pass without waiting for the consumer
   assign advance  = (phase == GEN_ACTIVE) && (!inDuty || ready);
   assign stepIncr = inDuty ? incr : '0;

   assign valid = (phase == GEN_ACTIVE) && inDuty;
   assign addr  = addrAcc;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         phase   <= GEN_IDLE;
         iterCnt <= '0;
         perCnt  <= '0;
         addrAcc <= '0;
         done    <= 1'b0;
      end
      else if (run)
      begin
         phase   <= GEN_ACTIVE;
         iterCnt <= '0;
         perCnt  <= '0;
         addrAcc <= '0;
         done    <= 1'b0;
      end
      else if (advance)
      begin
         if (lastStep)
         begin
            // end of period, shift comes on top of the step increment
            perCnt  <= '0;
            addrAcc <= addrAcc + stepIncr + shift;
            if (lastIter)
            begin
               phase <= GEN_IDLE;
               done  <= 1'b1;
            end
            else
            begin
               iterCnt <= iterCnt + 1'b1;
            end
         end
         else
         begin
            perCnt  <= perCnt + 1'b1;
            addrAcc <= addrAcc + stepIncr;
         end
      end
   end

endmodule

//--- addressGen2.sv
`timescale 1ns/1ps

module addressGen2
   import vReadPkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     run,
   input  memAddr_t iterations,
   input  memAddr_t start,
   input  memAddr_t shift,
   input  memAddr_t incr,
   input  memAddr_t iterations2,
   input  memAddr_t shift2,
   input  memAddr_t incr2,
   input  period_t  period,
   input  period_t  duty,
   input  period_t  delay,
   input  period_t  period2,
   output memAddr_t addr,
   output logic     memEn,
   output logic     done
);

   genPhase_t phase;
   period_t   delayCnt;
   memAddr_t  iterCnt;
   period_t   perCnt;
   memAddr_t  iter2Cnt;
   period_t   per2Cnt;
   memAddr_t  addrAcc;
   memAddr_t  outerAddr;
   logic      inDuty;
   logic      lastStep;
   logic      lastIter;
   logic      lastPer2;
   logic      lastIter2;
   period_t   lastDutyStep;
   logic      finalStep;
   memAddr_t  stepIncr;
   memAddr_t  outerNext;

   assign inDuty    = (perCnt < duty);
   assign lastStep  = (perCnt == period - 1'b1);
   assign lastIter  = (iterCnt == iterations - 1'b1);
   assign lastPer2  = (per2Cnt == period2 - 1'b1);
   assign lastIter2 = (iter2Cnt == iterations2 - 1'b1);
   assign stepIncr  = inDuty ? incr : '0;

   // last emitting step of a period, used to stop right after the final enable
   assign lastDutyStep = ((duty < period) ? duty : period) - 1'b1;
   assign finalStep    = lastIter && lastPer2 && lastIter2 &&
                         (lastStep || (perCnt == lastDutyStep));

   // outer level steps by incr2 and adds shift2 at the end of its period
   assign outerNext = outerAddr + incr2 + (lastPer2 ? shift2 : '0);

   assign memEn = (phase == GEN_ACTIVE) && inDuty;
   assign addr  = addrAcc;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         phase     <= GEN_IDLE;
         delayCnt  <= '0;
         iterCnt   <= '0;
         perCnt    <= '0;
         iter2Cnt  <= '0;
         per2Cnt   <= '0;
         addrAcc   <= '0;
         outerAddr <= '0;
         done      <= 1'b0;
      end
      else if (run)
      begin
         phase     <= (delay == '0) ? GEN_ACTIVE : GEN_DELAY;
         delayCnt  <= delay;
         iterCnt   <= '0;
         perCnt    <= '0;
         iter2Cnt  <= '0;
         per2Cnt   <= '0;
         addrAcc   <= start;
         outerAddr <= start;
         done      <= 1'b0;
      end
      else
      begin
         case (phase)
            GEN_DELAY:
            begin
               if (delayCnt == 1'b1)
                  phase <= GEN_ACTIVE;
               delayCnt <= delayCnt - 1'b1;
            end
            GEN_ACTIVE:
            begin
               if (finalStep)
               begin
                  phase <= GEN_IDLE;
                  done  <= 1'b1;
               end
               else if (lastStep)
               begin
                  perCnt <= '0;
                  if (lastIter)
                  begin
                     // inner sweep finished, restart it from the next outer base
                     iterCnt   <= '0;
                     addrAcc   <= outerNext;
                     outerAddr <= outerNext;
                     if (lastPer2)
                     begin
                        per2Cnt  <= '0;
                        iter2Cnt <= iter2Cnt + 1'b1;
                     end
                     else
                     begin
                        per2Cnt <= per2Cnt + 1'b1;
                     end
                  end
                  else
                  begin
                     iterCnt <= iterCnt + 1'b1;
                     addrAcc <= addrAcc + stepIncr + shift;
                  end
               end
               else
               begin
                  perCnt  <= perCnt + 1'b1;
                  addrAcc <= addrAcc + stepIncr;
               end
            end
            default:
               ;
         endcase
      end
   end

endmodule

//--- dualPortRam.sv
`timescale 1ns/1ps

module dualPortRam #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 10
)
(
   input  logic              clk,
   input  logic              wEn,
   input  logic [ADDR_W-1:0] wAddr,
   input  logic [DATA_W-1:0] wData,
   input  logic              rEn,
   input  logic [ADDR_W-1:0] rAddr,
   output logic [DATA_W-1:0] rData
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   // read before write on a shared address
   always_ff @(posedge clk)
   begin
      if (wEn)
         mem[wAddr] <= wData;
      if (rEn)
         rData <= mem[rAddr];
   end

endmodule

//--- memoryWriter.sv
`timescale 1ns/1ps

module memoryWriter
   import vReadPkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     genValid,
   output logic     genReady,
   input  memAddr_t genAddr,
   input  logic     dataValid,
   output logic     dataReady,
   input  word_t    dataIn,
   output logic     memEnable,
   output memAddr_t memAddr,
   output word_t    memData
);

   logic     pending;
   memAddr_t heldAddr;
   logic     beat;

   // request data as soon as an address is on offer
   assign dataReady = genValid || pending;
   assign beat      = dataReady && dataValid;

   // the generator is only released by an arriving bus beat
   assign genReady = beat;

   assign memEnable = beat;
   assign memAddr   = pending ? heldAddr : genAddr;
   assign memData   = dataIn;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         pending <= 1'b0;
      else if (beat)
         pending <= 1'b0;
      else if (genValid)
         pending <= 1'b1;
   end

   // address stays put while the bus stalls
   always_ff @(posedge clk)
   begin
      if (genValid && !pending && !dataValid)
         heldAddr <= genAddr;
   end

endmodule

//--- tb.f
+incdir+.
vReadPkg.sv
addressGen.sv
addressGen2.sv
memoryWriter.sv
dualPortRam.sv
vRead.sv
tb_vRead.sv

//--- tb_vRead.sv
`timescale 1ns/1ps
`include "vread_defs.svh"

module tb_vRead
   import vReadPkg::*;
();

   logic clk, rst, run, done;
   logic databusReady, databusValid, databusLast, outValid;
   ioAddr_t databusAddr, extAddr;
   word_t databusRdata, out0;
   logic [`LEN_W-1:0] databusLen, length;
   memAddr_t iterA, shiftA, incrA, iterB, startB, shiftB, incrB, iter2B, shift2B, incr2B;
   period_t perA, dutyA, perB, dutyB, delayB, per2B;
   logic pingPong, reverseB;

   int errors, checks, beatCnt;
   logic [31:0] lfsr;
   logic stallOn, compareOn, afterLast, tbBank;
   memAddr_t aQ[$];
   memAddr_t bQ[$];
   word_t expQ[$];
   word_t img[2**`MEM_ADDR_W];
   bit known[2**`MEM_ADDR_W];

   vRead uut (.*);

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // external memory word as a hash of its address
   function automatic word_t extMem(input logic [31:0] a);
      return (a * 32'h9e3779b1) ^ (a >> 7) ^ 32'h5a5a0f0f;
   endfunction

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic memAddr_t reverseAddr(input memAddr_t a);
      memAddr_t r;
      for (int i = 0; i < `MEM_ADDR_W; i++)
         r[i] = a[`MEM_ADDR_W-1-i];
      return r;
   endfunction

   // generator A address sequence
   task automatic buildA();
      memAddr_t addr;
      addr = '0;
      for (int i = 0; i < iterA; i++)
      begin
         for (int s = 0; s < perA; s++)
         begin
            if (s < dutyA)
            begin
               aQ.push_back(addr);
               addr = addr + incrA;
            end
         end
         addr = addr + shiftA;
      end
   endtask

   // generator B sequence where each inner sweep restarts from the outer base
   task automatic buildB();
      memAddr_t outer, addr;
      outer = pingPong ? {~tbBank, startB[`MEM_ADDR_W-2:0]} : startB;
      for (int i2 = 0; i2 < iter2B; i2++)
      begin
         for (int p2 = 0; p2 < per2B; p2++)
         begin
            addr = outer;
            for (int i = 0; i < iterB; i++)
            begin
               for (int s = 0; s < perB; s++)
               begin
                  if (s < dutyB)
                  begin
                     bQ.push_back(addr);
                     addr = addr + incrB;
                  end
               end
               addr = addr + shiftB;
            end
            outer = outer + incr2B + ((p2 == per2B - 1) ? shift2B : '0);
         end
      end
   endtask

   // bus memory model
   always @(posedge clk)
   begin
      if (afterLast && databusValid)
      begin
         $display("CHECK FAILED at %0t: databusValid high after databusLast", $time);
         errors++;
      end
      afterLast = 1'b0;
      if (run)
         beatCnt = 0;
      else if (databusValid && databusReady)
      begin
         checks++;
         if (databusAddr !== extAddr || databusLen !== length)
         begin
            $display("CHECK FAILED at %0t: bus address %h length %0d expected %h length %0d",
                     $time, databusAddr, databusLen, extAddr, length);
            errors++;
         end
         afterLast = databusLast;
         beatCnt++;
      end
      databusRdata <= extMem(extAddr + beatCnt);
      databusLast  <= (beatCnt == length);
      if (stallOn)
      begin
         lfsr = lfsrStep(lfsr);
         databusReady <= lfsr[0];
      end
      else
         databusReady <= 1'b1;
   end

   // output comparison
   always @(posedge clk)
   begin
      if (outValid && compareOn)
      begin
         checks++;
         if (expQ.size() == 0)
         begin
            $display("output word arrived when none was expected at %0t", $time);
            errors++;
         end
         else if (out0 !== expQ[0])
         begin
            $display("CHECK FAILED at %0t: out0 %h expected %h", $time, out0, expQ[0]);
            errors++;
            void'(expQ.pop_front());
         end
         else
            void'(expQ.pop_front());
      end
   end

   task automatic setA(input ioAddr_t ext, input memAddr_t it, input period_t per,
                       input period_t duty, input memAddr_t inc, input memAddr_t sh,
                       input logic [`LEN_W-1:0] len);
      @(posedge clk);
      extAddr <= ext;
      iterA   <= it;
      perA    <= per;
      dutyA   <= duty;
      incrA   <= inc;
      shiftA  <= sh;
      length  <= len;
   endtask

   task automatic setB(input memAddr_t st, input memAddr_t it, input period_t per,
                       input period_t duty, input memAddr_t inc, input memAddr_t sh,
                       input memAddr_t it2, input period_t per2, input memAddr_t inc2,
                       input memAddr_t sh2, input period_t dly, input logic rev);
      @(posedge clk);
      startB   <= st;
      iterB    <= it;
      perB     <= per;
      dutyB    <= duty;
      incrB    <= inc;
      shiftB   <= sh;
      iter2B   <= it2;
      per2B    <= per2;
      incr2B   <= inc2;
      shift2B  <= sh2;
      delayB   <= dly;
      reverseB <= rev;
   endtask

   task automatic waitDone();
      int cycles;
      cycles = 0;
      @(negedge clk);
      checks++;
      if (done)
      begin
         $display("CHECK FAILED at %0t: done high right after run", $time);
         errors++;
      end
      while (!done && cycles < 5000)
      begin
         @(negedge clk);
         cycles++;
      end
      if (!done)
      begin
         $display("timeout, done never rose after run");
         errors++;
      end
      else
      begin
         checks++;
         if (beatCnt != length + 1 || expQ.size() > 1)
         begin
            $display("CHECK FAILED at %0t: done before bus or B finished", $time);
            errors++;
         end
      end
      // last output follows doneB by one cycle
      repeat (2) @(negedge clk);
      if (expQ.size() != 0)
      begin
         $display("CHECK FAILED at %0t: %0d output words missing", $time, expQ.size());
         errors++;
         expQ.delete();
      end
   endtask

   task automatic doRun(input bit cmp);
      memAddr_t wa, ra;
      @(negedge clk);
      aQ.delete();
      bQ.delete();
      tbBank = pingPong ? !tbBank : 1'b0;
      buildA();
      if (aQ.size() != length + 1)
      begin
         $display("test setup error, length does not match generator A count");
         errors++;
      end
      foreach (aQ[k])
      begin
         wa = pingPong ? {tbBank, aQ[k][`MEM_ADDR_W-2:0]} : aQ[k];
         img[wa]   = extMem(extAddr + k);
         known[wa] = 1'b1;
      end
      if (cmp)
      begin
         buildB();
         foreach (bQ[k])
         begin
            ra = reverseB ? reverseAddr(bQ[k]) : bQ[k];
            if (!known[ra])
            begin
               $display("test setup error, B reads unwritten address %0d", ra);
               errors++;
            end
            expQ.push_back(img[ra]);
         end
      end
      compareOn = cmp;
      @(posedge clk);
      run <= 1'b1;
      @(posedge clk);
      run <= 1'b0;
      waitDone();
   endtask

   initial
   begin
      errors = 0;
      checks = 0;
      beatCnt = 0;
      lfsr = 32'h26e6;
      stallOn = 0;
      compareOn = 0;
      afterLast = 0;
      tbBank = 0;
      rst = 1'b1;
      run = 1'b0;
      databusReady = 1'b0;
      databusRdata = '0;
      databusLast = 1'b0;
      extAddr = '0;
      iterA = '0;
      perA = '0;
      dutyA = '0;
      shiftA = '0;
      incrA = '0;
      length = '0;
      pingPong = 1'b0;
      iterB = '0;
      perB = '0;
      dutyB = '0;
      startB = '0;
      shiftB = '0;
      incrB = '0;
      delayB = '0;
      reverseB = 1'b0;
      iter2B = '0;
      per2B = '0;
      shift2B = '0;
      incr2B = '0;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      checks++;
      if (done || databusValid || outValid)
      begin
         $display("CHECK FAILED at %0t: outputs not low after reset", $time);
         errors++;
      end
      // linear burst and linear sweep
      setA(100, 1, 64, 64, 1, 0, 63);
      setB(0, 1, 64, 64, 1, 0, 1, 1, 0, 0, 0, 1'b0);
      doRun(0);
      doRun(1);
      // strided duty-gated burst under stalls
      // a linear B sweep covers the written words and the gaps between them
      stallOn = 1'b1;
      setA(300, 4, 6, 3, 2, 5, 11);
      setB(0, 1, 38, 38, 1, 0, 1, 1, 0, 0, 0, 1'b0);
      doRun(0);
      doRun(1);
      // two-level B with a start delay
      setA(1000, 1, 64, 64, 1, 0, 63);
      setB(3, 2, 4, 2, 1, 3, 2, 2, 4, 6, 5, 1'b0);
      doRun(0);
      doRun(1);
      // bit-reversed reads over a stride of 64
      setA(1500, 1, 16, 16, 64, 0, 15);
      setB(0, 1, 16, 16, 1, 0, 1, 1, 0, 0, 0, 1'b1);
      doRun(0);
      doRun(1);
      // second ping-pong run reads the bank of the first
      setA(2000, 1, 16, 16, 1, 0, 15);
      setB(0, 1, 16, 16, 1, 0, 1, 1, 0, 0, 0, 1'b0);
      @(posedge clk);
      pingPong <= 1'b1;
      doRun(0);
      setA(3000, 1, 16, 16, 1, 0, 15);
      doRun(1);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

//--- vRead.sv
`timescale 1ns/1ps
`include "vread_defs.svh"

module vRead
   import vReadPkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              run,
   output logic              done,
   // native bus in the read direction
   input  logic              databusReady,
   output logic              databusValid,
   output ioAddr_t           databusAddr,
   input  word_t             databusRdata,
   output logic [`LEN_W-1:0] databusLen,
   input  logic              databusLast,
   // output stream
   output word_t             out0,
   output logic              outValid,
   // configuration
   input  ioAddr_t           extAddr,
   input  memAddr_t          iterA,
   input  period_t           perA,
   input  period_t           dutyA,
   input  memAddr_t          shiftA,
   input  memAddr_t          incrA,
   input  logic [`LEN_W-1:0] length,
   input  logic              pingPong,
   input  memAddr_t          iterB,
   input  period_t           perB,
   input  period_t           dutyB,
   input  memAddr_t          startB,
   input  memAddr_t          shiftB,
   input  memAddr_t          incrB,
   input  period_t           delayB,
   input  logic              reverseB,
   input  memAddr_t          iter2B,
   input  period_t           per2B,
   input  memAddr_t          shift2B,
   input  memAddr_t          incr2B
);

   logic     bank;
   logic     doneA;
   logic     doneB;
   logic     genValid;
   logic     genReady;
   memAddr_t genAddr;
   logic     wrEn;
   memAddr_t wrAddr;
   memAddr_t wrAddrBanked;
   word_t    wrData;
   memAddr_t startBBanked;
   memAddr_t addrB;
   memAddr_t rdAddr;
   logic     enB;

   function automatic memAddr_t reverseBits(input memAddr_t word);
      memAddr_t res;
      for (int i = 0; i < `MEM_ADDR_W; i++)
         res[i] = word[`MEM_ADDR_W-1-i];
      return res;
   endfunction

   assign databusLen = length;
   assign done       = doneA && doneB;

   // writer fills one bank while B sweeps the other
   // B latches its start on run, while bank still names the previous burst
   assign wrAddrBanked = pingPong ? {bank, wrAddr[`MEM_ADDR_W-2:0]} : wrAddr;
   assign startBBanked = pingPong ? {bank, startB[`MEM_ADDR_W-2:0]} : startB;

   assign rdAddr = reverseB ? reverseBits(addrB) : addrB;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         databusAddr <= '0;
         bank        <= 1'b0;
      end
      else if (run)
      begin
         databusAddr <= extAddr;
         bank        <= pingPong ? !bank : 1'b0;
      end
   end

   // bus side is finished once the last beat is taken
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         doneA <= 1'b0;
      else if (run)
         doneA <= 1'b0;
      else if (databusValid && databusReady && databusLast)
         doneA <= 1'b1;
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         outValid <= 1'b0;
      else
         outValid <= enB;
   end

   addressGen genA (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .iterations (iterA),
      .period     (perA),
      .duty       (dutyA),
      .shift      (shiftA),
      .incr       (incrA),
      .valid      (genValid),
      .ready      (genReady),
      .addr       (genAddr),
      .done       ()
   );

   addressGen2 genB (
      .clk         (clk),
      .rst         (rst),
      .run         (run),
      .iterations  (iterB),
      .start       (startBBanked),
      .shift       (shiftB),
      .incr        (incrB),
      .iterations2 (iter2B),
      .shift2      (shift2B),
      .incr2       (incr2B),
      .period      (perB),
      .duty        (dutyB),
      .delay       (delayB),
      .period2     (per2B),
      .addr        (addrB),
      .memEn       (enB),
      .done        (doneB)
   );

   memoryWriter writer (
      .clk       (clk),
      .rst       (rst),
      .genValid  (genValid),
      .genReady  (genReady),
      .genAddr   (genAddr),
      .dataValid (databusReady),
      .dataReady (databusValid),
      .dataIn    (databusRdata),
      .memEnable (wrEn),
      .memAddr   (wrAddr),
      .memData   (wrData)
   );

   dualPortRam #(
      .DATA_W (`DATA_W),
      .ADDR_W (`MEM_ADDR_W)
   ) mem (
      .clk   (clk),
      .wEn   (wrEn),
      .wAddr (wrAddrBanked),
      .wData (wrData),
      .rEn   (enB),
      .rAddr (rdAddr),
      .rData (out0)
   );

endmodule

//--- vReadPkg.sv
`include "vread_defs.svh"

package vReadPkg;

   // local RAM address
   typedef logic [`MEM_ADDR_W-1:0] memAddr_t;

   // external address on the native bus
   typedef logic [`IO_ADDR_W-1:0] ioAddr_t;

   // period, duty and delay counts
   typedef logic [`PERIOD_W-1:0] period_t;

   // data word
   typedef logic [`DATA_W-1:0] word_t;

   // generator phase, the delay phase is only used by the two-level generator
   typedef enum logic [1:0]
   {
      GEN_IDLE   = 2'd0,
      GEN_DELAY  = 2'd1,
      GEN_ACTIVE = 2'd2
   } genPhase_t;

endpackage

//--- vread_defs.svh
`ifndef VREAD_DEFS_SVH
`define VREAD_DEFS_SVH

// data word carried by the bus and stored in the local RAM
`define DATA_W 32

// local RAM address, also the width of generator addresses
`define MEM_ADDR_W 10

// external byte address on the native bus
`define IO_ADDR_W 32

// period, duty and delay counters of the generators
`define PERIOD_W 10

// burst length field, word count minus one
`define LEN_W 8

`endif
